// File: hdl/colorOut.sv
// Master palette lookup and registered RGB565 output, blanked outside the visible area
`timescale 1ns/1ps
`include "nesPalette.svh"

module colorOut (
    input  logic                              CLK25,
    input  logic                              rst,
    input  logic                              visible,
    input  logic [ppuPkg::colorIdxWidth-1:0]  backdrop,
    output logic [4:0]                        red,
    output logic [5:0]                        green,
    output logic [4:0]                        blue
);
    import ppuPkg::*;

    logic [15:0] rgb;

    assign rgb = nesPalette[backdrop];      // Index to RGB565

    always_ff @(posedge CLK25) begin
        if (rst) begin
            {red, green, blue} <= '0;
        end else if (visible) begin
            red   <= rgb[4:0];              // Low field drives red
            green <= rgb[10:5];
            blue  <= rgb[15:11];
        end else begin
            {red, green, blue} <= '0;       // Black in blanking
        end
    end

endmodule

// File: hdl/paletteRam.sv
// Background and sprite palette tables with one CPU port and the backdrop output
`timescale 1ns/1ps

module paletteRam (
    input  logic                              CLK25,
    input  logic                              rst,
    input  logic                              palWe,
    input  logic [4:0]                        palAddr,
    input  logic [ppuPkg::colorIdxWidth-1:0]  palWdata,
    output logic [ppuPkg::colorIdxWidth-1:0]  palRdata,
    output logic [ppuPkg::colorIdxWidth-1:0]  backdrop
);
    import ppuPkg::*;

    logic [colorIdxWidth-1:0] bgPal [16];   // 0x3F00-0x3F0F
    logic [colorIdxWidth-1:0] spPal [16];   // 0x3F10-0x3F1F

    always_ff @(posedge CLK25) begin
        if (rst) begin
            for (int i = 0; i < 16; i++) begin
                bgPal[i] <= bgPalReset[i];
                spPal[i] <= '0;
            end
        end else if (palWe) begin
            if (palAddr[4]) spPal[palAddr[3:0]] <= palWdata;
            else            bgPal[palAddr[3:0]] <= palWdata;
        end
    end

    // Read is combinational
    assign palRdata = palAddr[4] ? spPal[palAddr[3:0]] : bgPal[palAddr[3:0]];
    assign backdrop = bgPal[0];     // Universal background colour

endmodule

// File: hdl/ppuPkg.sv
// Picture processor constants: VGA timing, address windows, reset palette, register and FSM enums
package ppuPkg;

    // --------------------
    // VGA 640x480 timing
    localparam int hVisible = 640;          // Pixels shown
    localparam int hFront   = 16;
    localparam int hSync    = 96;           // hs pulse width
    localparam int hWhole   = 800;          // Full line incl. porches

    localparam int vVisible = 480;          // Lines shown
    localparam int vFront   = 10;
    localparam int vSync    = 2;
    localparam int vWhole   = 525;

    // Console scanlines, each two VGA lines
    localparam int vblankLine    = 241;     // VBlank and NMI set
    localparam int vblankEndLine = 260;     // VBlank and NMI cleared

    // --------------------
    // PPU address windows
    localparam logic [15:0] vramBase      = 16'h2000;
    localparam logic [15:0] paletteBase   = 16'h3F00;   // Background palette
    localparam logic [15:0] spritePalBase = 16'h3F10;   // Sprite palette
    localparam logic [15:0] paletteEnd    = 16'h3F20;

    localparam logic [5:0] incWide = 6'd32;             // Vertical write step
    localparam int colorIdxWidth   = 6;                 // Master palette index

    // Power-up background palette, gaps left at zero
    localparam logic [colorIdxWidth-1:0] bgPalReset [16] = '{
        6'h12, 6'h16, 6'h30, 6'h38, 6'h00, 6'h17, 6'h26, 6'h07,
        6'h00, 6'h16, 6'h00, 6'h30, 6'h00, 6'h38, 6'h28, 6'h10
    };

    // CPU visible registers, by ea[2:0]
    typedef enum logic [2:0] {
        regCtrl   = 3'd0,
        regNone   = 3'd1,   // Any unhandled offset
        regStatus = 3'd2,
        regAddr   = 3'd6,
        regData   = 3'd7
    } regSel;

    // Register access sequencing
    typedef enum logic [1:0] {accIdle, accExec, accStep} accState;

endpackage

// File: hdl/ppuRegs.sv
// PPU register file: control, address pair, read buffer, VBlank/NMI, VRAM and palette ports
`timescale 1ns/1ps

module ppuRegs (
    input  logic                              CLK25,
    input  logic                              rst,
    input  logic [7:0]                        din,
    input  ppuPkg::regSel                     sel,
    input  logic                              execWr,
    input  logic                              execRd,
    input  logic                              step,
    input  logic [7:0]                        VIN,
    input  logic [ppuPkg::colorIdxWidth-1:0]  palRdata,
    input  logic [8:0]                        ppuLine,
    input  logic                              vblankSet,
    input  logic                              vblankClr,
    output logic [7:0]                        DOUT,
    output logic                              NMI,
    output logic                              WVREQ,
    output logic [12:0]                       WADDR,
    output logic [7:0]                        WDATA,
    output logic                              palWe,
    output logic [4:0]                        palAddr,
    output logic [ppuPkg::colorIdxWidth-1:0]  palWdata
);
    import ppuPkg::*;

    logic [7:0]  ctrl0;         // 7 NMI enable, 2 increment, 1:0 nametable
    logic [15:0] addr;          // VRAM pointer
    logic        firstW;        // Next address write is the high byte
    logic [7:0]  readBuf;       // Delayed VRAM read data
    logic        bufPend;       // Buffer refill due in step
    logic        vblank;
    logic        belowPalette, inVram, inPalette;
    logic        dataWr, dataRd, statusRd;

    // --------------------
    // Address window decode
    assign belowPalette = (addr < paletteBase);
    assign inVram       = (addr >= vramBase) && belowPalette;
    assign inPalette    = !belowPalette && (addr < paletteEnd);

    assign dataWr   = execWr && (sel == regData);
    assign dataRd   = execRd && (sel == regData);
    assign statusRd = execRd && (sel == regStatus);

    // External VRAM write port, valid during exec
    assign WVREQ = dataWr && inVram;
    assign WADDR = addr[12:0];
    assign WDATA = din;

    // Palette port, bit 4 picks the sprite table
    assign palWe    = dataWr && inPalette;
    assign palAddr  = {addr >= spritePalBase, addr[3:0]};
    assign palWdata = din[colorIdxWidth-1:0];

    // --------------------
    always_ff @(posedge CLK25) begin
        if (rst) begin
            ctrl0   <= '0;
            addr    <= '0;
            firstW  <= 1'b1;
            readBuf <= 8'hFF;
            bufPend <= 1'b0;
            DOUT    <= '0;
        end else begin
            if (execWr) begin
                case (sel)
                    regCtrl: ctrl0 <= din;
                    regAddr: begin
                        if (firstW) addr[15:8] <= din;  // High byte first
                        else        addr[7:0]  <= din;
                        firstW <= !firstW;
                    end
                    default: ;
                endcase
            end
            if (statusRd) begin
                DOUT   <= {vblank, 2'b00, ppuLine > 9'(vblankLine), 4'b0000};
                firstW <= 1'b1;                         // Restart address pair
            end
            if (dataRd) begin
                if (belowPalette)   DOUT <= readBuf;    // Previous fetch
                else if (inPalette) DOUT <= 8'(palRdata);
            end
            bufPend <= dataRd && belowPalette;
            // Advance pointer, refill buffer from VRAM
            if (step && (sel == regData)) begin
                addr <= addr + (ctrl0[2] ? 16'(incWide) : 16'd1);
                if (bufPend) readBuf <= VIN;
            end
        end
    end

    // VBlank flag and NMI; status read beats a set in the same cycle
    always_ff @(posedge CLK25) begin
        if (rst) begin
            vblank <= 1'b0;
            NMI    <= 1'b0;
        end else begin
            if (statusRd)       vblank <= 1'b0;
            else if (vblankSet) vblank <= 1'b1;
            else if (vblankClr) vblank <= 1'b0;
            if (vblankSet)      NMI <= ctrl0[7];
            else if (vblankClr) NMI <= 1'b0;
        end
    end

    aVramOnly: assert property (@(posedge CLK25) disable iff (rst)
        $rose(WVREQ) |-> (addr >= vramBase && addr < paletteBase));

endmodule

// File: hdl/ppuTop.sv
// PPU top level: timer, access FSM, register block, palette and colour output
`timescale 1ns/1ps

module ppuTop (
    input  logic        CLK25,
    input  logic        rst,
    input  logic [15:0] ea,         // CPU address
    input  logic [7:0]  din,
    input  logic        WREQ,
    input  logic        RD,
    output logic [7:0]  DOUT,
    output logic        NMI,
    input  logic [7:0]  VIN,        // VRAM read data
    output logic        WVREQ,
    output logic [12:0] WADDR,
    output logic [7:0]  WDATA,
    output logic [4:0]  red,
    output logic [5:0]  green,
    output logic [4:0]  blue,
    output logic        hs,
    output logic        vs
);
    logic visible, vblankSet, vblankClr;
    logic [8:0] ppuLine;
    logic execWr, execRd, accStep, palWe;
    ppuPkg::regSel accSel;
    logic [4:0] palAddr;
    logic [ppuPkg::colorIdxWidth-1:0] palWdata, palRdata, backdrop;

    vgaTimer uTimer (.CLK25, .rst, .hs, .vs, .visible, .ppuLine, .vblankSet, .vblankClr);

    regAccessFsm uFsm (.CLK25, .rst, .ea, .WREQ, .RD, .execWr, .execRd,
                       .step(accStep), .sel(accSel));

    ppuRegs uRegs (.CLK25, .rst, .din, .sel(accSel), .execWr, .execRd, .step(accStep),
                   .VIN, .palRdata, .ppuLine, .vblankSet, .vblankClr, .DOUT, .NMI,
                   .WVREQ, .WADDR, .WDATA, .palWe, .palAddr, .palWdata);

    paletteRam uPal (.CLK25, .rst, .palWe, .palAddr, .palWdata, .palRdata, .backdrop);

    colorOut uColor (.CLK25, .rst, .visible, .backdrop, .red, .green, .blue);

endmodule

// File: hdl/regAccessFsm.sv
// CPU register access FSM: window decode, register select latch, execute and advance steps
`timescale 1ns/1ps

module regAccessFsm (
    input  logic          CLK25,
    input  logic          rst,
    input  logic [15:0]   ea,
    input  logic          WREQ,
    input  logic          RD,
    output logic          execWr,
    output logic          execRd,
    output logic          step,
    output ppuPkg::regSel sel
);
    import ppuPkg::*;

    accState state;
    regSel   selNow;        // Decode of the current offset
    logic    isWrite;       // Kind of the access in flight
    logic    inWindow;

    assign inWindow = (ea[15:13] == vramBase[15:13]);  // 0x2000-0x3FFF

    // Register offset decode
    always_comb begin
        case (ea[2:0])
            3'd0:    selNow = regCtrl;
            3'd2:    selNow = regStatus;
            3'd6:    selNow = regAddr;
            3'd7:    selNow = regData;
            default: selNow = regNone;
        endcase
    end

    // --------------------
    always_ff @(posedge CLK25) begin
        if (rst) begin
            state   <= accIdle;
            isWrite <= 1'b0;
            sel     <= regNone;
        end else begin
            case (state)
                accIdle: if (inWindow && (WREQ || RD)) begin
                    state   <= accExec;
                    isWrite <= WREQ;    // Write wins if both strobes
                    sel     <= selNow;  // Held for the whole access
                end
                accExec: state <= accStep;
                accStep: state <= accIdle;
                default: state <= accIdle;
            endcase
        end
    end

    assign execWr = (state == accExec) && isWrite;
    assign execRd = (state == accExec) && !isWrite;
    assign step   = (state == accStep);

    // A strobe mid-access gets dropped
    aNoOverlap: assert property (@(posedge CLK25) disable iff (rst)
        (state != accIdle && inWindow) |-> !(WREQ || RD));

endmodule

// File: hdl/vgaTimer.sv
// VGA pixel and line counters, hs/vs decode, visible flag, console scanline and VBlank strobes
`timescale 1ns/1ps

module vgaTimer (
    input  logic       CLK25,
    input  logic       rst,
    output logic       hs,
    output logic       vs,
    output logic       visible,
    output logic [8:0] ppuLine,
    output logic       vblankSet,
    output logic       vblankClr
);
    import ppuPkg::*;

    logic [9:0] x;          // Pixel within line
    logic [9:0] y;          // Line within frame
    logic       lineStart;  // First pixel of a line

    // --------------------
    // Raster counters
    always_ff @(posedge CLK25) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else begin
            x <= (x == 10'(hWhole - 1)) ? '0 : x + 1'b1;
            if (x == 10'(hWhole - 1)) begin   // End of line
                y <= (y == 10'(vWhole - 1)) ? '0 : y + 1'b1;
            end
        end
    end

    // Sync pulses sit after the front porch
    assign hs      = (x >= 10'(hVisible + hFront)) && (x < 10'(hVisible + hFront + hSync));
    assign vs      = (y >= 10'(vVisible + vFront)) && (y < 10'(vVisible + vFront + vSync));
    assign visible = (x < 10'(hVisible)) && (y < 10'(vVisible));

    // Console scanline is every second VGA line
    assign ppuLine   = y[9:1];
    assign lineStart = (x == '0);
    assign vblankSet = lineStart && (y == 10'(2 * vblankLine));     // Entry of line 241
    assign vblankClr = lineStart && (y == 10'(2 * vblankEndLine));  // Entry of line 260

    aPixWrap: assert property (@(posedge CLK25) disable iff (rst) x < 10'(hWhole));
    aStrobeExcl: assert property (@(posedge CLK25) disable iff (rst) !(vblankSet && vblankClr));

endmodule

// File: include/nesPalette.svh
// Master palette table from 6-bit colour index to RGB565
`ifndef NES_PALETTE_SVH
`define NES_PALETTE_SVH

localparam logic [15:0] nesPalette [64] = '{
    // --------------------
    16'h73ae,   // 0x00
    16'h88c4,
    16'ha800,
    16'h9808,
    16'h7011,
    16'h1015,
    16'h0014,
    16'h004f,
    16'h0168,   // 0x08
    16'h0220,
    16'h0280,
    16'h11e0,
    16'h59e3,
    16'h0000,   // Unused slots
    16'h0000,
    16'h0000,
    // --------------------
    16'hbdf7,   // 0x10
    16'heb80,
    16'he9c4,
    16'hf010,
    16'hb817,
    16'h581c,
    16'h015b,
    16'h0a79,
    16'h0391,   // 0x18
    16'h04a0,
    16'h0540,
    16'h3c80,
    16'h8c00,
    16'h0000,
    16'h0000,
    16'h0000,
    // --------------------
    16'hffff,   // 0x20
    16'hfde7,
    16'hfcab,
    16'hfc54,
    16'hfbde,
    16'hb3bf,
    16'h63bf,
    16'h3cdf,
    16'h3dfe,   // 0x28
    16'h1690,
    16'h4ee9,
    16'h9fcb,
    16'hdf40,
    16'h0000,
    16'h0000,
    16'h0000,
    // --------------------
    16'hffff,   // 0x30
    16'hff35,
    16'hfeb8,
    16'hfe5a,
    16'hfe3f,
    16'hde3f,
    16'hb5ff,
    16'haedf,
    16'ha73f,   // 0x38
    16'ha7fc,
    16'hbf95,
    16'hcff6,
    16'hf7f3,
    16'h0000,
    16'h0000,
    16'h0000
};

`endif

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ppuTb -f src.f -o ppuSim > build.log 2>&1 \
    && ./obj_dir/ppuSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0

// File: src.f
+incdir+include
hdl/ppuPkg.sv
hdl/vgaTimer.sv
hdl/regAccessFsm.sv
hdl/ppuRegs.sv
hdl/paletteRam.sv
hdl/colorOut.sv
hdl/ppuTop.sv
tests/ppuTb.sv

// File: tests/ppuTb.sv
// Testbench with clock, VRAM model, stimulus table, VRAM write log, status and video checks
`timescale 1ns/1ps
`include "nesPalette.svh"

module ppuTb;
    import ppuPkg::*;

    localparam logic [1:0] kWrite = 2'd0, kRead = 2'd1, kWaitNmi = 2'd2, kWaitHs = 2'd3;
    localparam int sigNmi = 0, sigHs = 1, sigVs = 2;
    localparam int frameLimit = hWhole * vWhole + hWhole;     // One frame and a line
    localparam int hsTail     = hWhole - (hVisible + hFront + hSync);  // End of hs to line end

    typedef struct packed {
        logic [3:0]  test;
        logic [1:0]  kind;
        logic [15:0] ea;
        logic [7:0]  data;      // Write data, expected DOUT, NMI level or hs pulse count
        logic [19:0] limit;     // Timeout of a wait, in cycles
    } stimRow;

    typedef struct packed {
        logic [3:0]  test;
        logic [12:0] addr;
        logic [7:0]  data;
    } vramWr;

    logic        CLK25, rst, WREQ, RD, NMI, WVREQ, hs, vs;
    logic [15:0] ea;
    logic [7:0]  din, DOUT, VIN, WDATA;
    logic [12:0] WADDR;
    logic [4:0]  red, blue;
    logic [5:0]  green;

    logic [7:0]  vram [2048];   // 2 KB nametable memory
    stimRow      rows [$];
    vramWr       expWr [$];     // Expected WVREQ pulses in order
    vramWr       wrLog [$];     // Seen WVREQ pulses
    logic [15:0] lfsr;
    logic [3:0]  buildId;
    logic        timedOut;
    int          errCount, errAtStart, passCount, failCount;

    ppuTop UUT (.CLK25, .rst, .ea, .din, .WREQ, .RD, .DOUT, .NMI, .VIN, .WVREQ, .WADDR,
                .WDATA, .red, .green, .blue, .hs, .vs);

    initial begin
        CLK25 = 1'b0;
        forever #50 CLK25 = ~CLK25;
    end

    // --------------------
    // VRAM model with combinational read
    assign VIN = vram[WADDR[10:0]];

    // Write port sampled mid-cycle, where WVREQ is settled
    always @(negedge CLK25) begin
        if (WVREQ) begin
            vram[WADDR[10:0]] <= WDATA;
            wrLog.push_back(vramWr'{4'd0, WADDR, WDATA});  // One entry per cycle high
        end
    end

    // Galois LFSR stepped once per bit
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) lfsr = lfsr ^ 16'hB400;
        return outBit;
    endfunction

    function automatic logic [7:0] randByte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) b = {b[6:0], lfsrBit()};
        return b;
    endfunction

    function automatic logic probe(input int sigId);
        case (sigId)
            sigNmi:  return NMI;
            sigHs:   return hs;
            default: return vs;
        endcase
    endfunction

    task automatic checkEq(input logic [15:0] got, input logic [15:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            errCount++;
        end
    endtask

    // Poll at the falling edge until the level shows up
    task automatic waitFor(input int sigId, input logic level, input int limit, input string what);
        int n;
        n = 0;
        if (timedOut) return;
        while (probe(sigId) != level && n < limit) begin
            @(negedge CLK25);
            n++;
        end
        if (probe(sigId) != level) begin
            $display("timeout: %s did not happen within %0d cycles", what, limit);
            errCount++;
            timedOut = 1'b1;
        end
    endtask

    // --------------------
    // Table building
    task automatic pushRow(input logic [1:0] kind, input logic [15:0] addr,
                           input logic [7:0] data, input logic [19:0] limit);
        rows.push_back(stimRow'{buildId, kind, addr, data, limit});
    endtask

    task automatic addWrite(input logic [15:0] addr, input logic [7:0] data);
        pushRow(kWrite, addr, data, '0);
    endtask

    task automatic addRead(input logic [15:0] addr, input logic [7:0] expDout);
        pushRow(kRead, addr, expDout, '0);
    endtask

    task automatic setAddr(input logic [15:0] a);
        addWrite(16'h2006, a[15:8]);    // High byte first
        addWrite(16'h2006, a[7:0]);
    endtask

    task automatic expectVram(input logic [12:0] a, input logic [7:0] d);
        expWr.push_back(vramWr'{buildId, a, d});
    endtask

    task automatic buildTable();
        logic [7:0] r [6];
        logic [7:0] p0, p1;
        lfsr = 16'd51;
        for (int i = 0; i < 6; i++) r[i] = randByte();
        p0 = randByte();
        p1 = randByte();
        buildId = 4'd1;                         // VRAM writes with step 1 then 32
        addWrite(16'h2000, 8'h00);
        setAddr(16'h2100);
        for (int i = 0; i < 3; i++) begin
            addWrite(16'h2007, r[i]);
            expectVram(13'h100 + 13'(i), r[i]);
        end
        addWrite(16'h2000, 8'h04);
        setAddr(16'h2140);
        addWrite(16'h2007, r[3]);
        expectVram(13'h140, r[3]);
        addWrite(16'h2007, r[4]);
        expectVram(13'h160, r[4]);
        buildId = 4'd2;                         // Reads lag one behind
        addWrite(16'h2000, 8'h00);
        setAddr(16'h2100);
        addRead(16'h2007, 8'hFF);               // Buffer still at reset value
        addRead(16'h2007, r[0]);
        addRead(16'h2007, r[1]);
        buildId = 4'd3;                         // Palette with 6-bit entries
        setAddr(16'h3F03);
        addWrite(16'h2007, p0);
        setAddr(16'h3F13);
        addWrite(16'h2007, p1);
        setAddr(16'h3F03);
        addRead(16'h2007, p0 & 8'h3F);
        setAddr(16'h3F13);
        addRead(16'h2007, p1 & 8'h3F);
        setAddr(16'h3F01);
        addRead(16'h2007, 8'h16);
        buildId = 4'd4;                         // Status, VBlank, NMI
        addWrite(16'h2000, 8'h80);
        addWrite(16'h2006, 8'h3F);              // Lone high byte
        pushRow(kWaitNmi, 16'h0, 8'd1, 20'(frameLimit));
        pushRow(kWaitHs, 16'h0, 8'd3, 20'(hWhole + 8));    // On to scanline 242
        addRead(16'h2002, 8'h90);
        addRead(16'h2002, 8'h10);
        setAddr(16'h2180);                      // Pair restarted by status read
        addWrite(16'h2007, r[5]);
        expectVram(13'h180, r[5]);
        pushRow(kWaitNmi, 16'h0, 8'd0, 20'(39 * hWhole));  // Before next frame
        buildId = 4'd5;                         // Backdrop
        setAddr(16'h3F00);
        addWrite(16'h2007, 8'h21);
    endtask

    // --------------------
    task automatic applyRow(input stimRow r);
        case (r.kind)
            kWrite, kRead: begin
                ea   = r.ea;
                din  = (r.kind == kWrite) ? r.data : 8'h00;
                WREQ = (r.kind == kWrite);
                RD   = (r.kind == kRead);
                @(negedge CLK25);               // Strobe taken at the rising edge between
                WREQ = 1'b0;
                RD   = 1'b0;
                repeat (2) @(negedge CLK25);    // Execute then advance
                repeat (4) @(negedge CLK25);
                if (r.kind == kRead) begin
                    checkEq(16'(DOUT), 16'(r.data), $sformatf("DOUT after read of 0x%h", r.ea));
                end
            end
            kWaitNmi: waitFor(sigNmi, r.data[0], int'(r.limit), "NMI level change");
            default: begin
                for (int k = 0; k < int'(r.data); k++) begin
                    waitFor(sigHs, 1'b1, int'(r.limit), "hs pulse start");
                    waitFor(sigHs, 1'b0, int'(r.limit), "hs pulse end");
                end
            end
        endcase
    endtask

    task automatic checkVideo();
        logic [15:0] rgb, want;
        int xs [4] = '{5, 200, 400, 639};
        int done, hsHigh, lit, vsHigh;
        rgb    = nesPalette[6'h21];
        want   = {rgb[4:0], rgb[10:5], rgb[15:11]};    // Red sits in the low field
        done   = 0;
        hsHigh = 0;
        lit    = 0;
        vsHigh = 0;
        waitFor(sigVs, 1'b1, frameLimit, "vs pulse start");
        if (timedOut) return;
        while (vs && vsHigh < 3 * hWhole) begin         // Width of the vs pulse
            @(negedge CLK25);
            vsHigh++;
        end
        checkEq(16'(vsHigh), 16'd1600, "vs high cycles per frame");     // Two whole lines
        waitFor(sigVs, 1'b0, 3 * hWhole, "vs pulse end");
        // One hs pulse per line up to and including line 0
        for (int k = 0; k < vWhole - (vVisible + vFront + vSync) + 1; k++) begin
            waitFor(sigHs, 1'b1, hWhole + 8, "hs pulse start");
            waitFor(sigHs, 1'b0, hWhole + 8, "hs pulse end");
        end
        if (timedOut) return;
        foreach (xs[j]) begin
            repeat (hsTail + xs[j] - done) @(negedge CLK25);
            done = hsTail + xs[j];
            checkEq({red, green, blue}, want, $sformatf("RGB at pixel %0d of line 1", xs[j]));
        end
        for (int n = 0; n < hWhole; n++) begin  // One whole line
            @(negedge CLK25);
            if (hs) begin
                hsHigh++;
                if ({red, green, blue} != 16'd0) lit++;
            end
        end
        checkEq(16'(hsHigh), 16'd96, "hs high cycles per line");
        checkEq(16'(lit), 16'd0, "non-black cycles during hs");
    endtask

    task automatic finishTest(input int id);
        vramWr want, seen;
        int    errs;
        if (id == 5 && !timedOut) checkVideo();
        while (expWr.size() > 0 && expWr[0].test == 4'(id)) begin
            want = expWr.pop_front();
            if (wrLog.size() == 0) begin
                $display("VRAM write of 0x%h to 0x%h never happened", want.data, want.addr);
                errCount++;
            end else begin
                seen = wrLog.pop_front();
                checkEq(16'(seen.addr), 16'(want.addr), "WADDR of VRAM write");
                checkEq(16'(seen.data), 16'(want.data), "WDATA of VRAM write");
            end
        end
        while (wrLog.size() > 0) begin
            seen = wrLog.pop_front();
            $display("unexpected VRAM write to 0x%h", seen.addr);
            errCount++;
        end
        errs       = errCount - errAtStart;
        errAtStart = errCount;
        if (errs == 0) passCount++;
        else failCount++;
        $display("test %0d finished with %0d errors", id, errs);
    endtask

    // --------------------
    initial begin
        rst        = 1'b1;
        ea         = '0;
        din        = '0;
        WREQ       = 1'b0;
        RD         = 1'b0;
        timedOut   = 1'b0;
        errCount   = 0;
        errAtStart = 0;
        passCount  = 0;
        failCount  = 0;
        buildTable();
        repeat (8) @(negedge CLK25);
        rst = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            applyRow(rows[i]);
            if (timedOut || i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                finishTest(int'(rows[i].test));
            end
            if (timedOut) break;
        end
        $display("%0d tests passed, %0d failed, %0d errors", passCount, failCount, errCount);
        if (errCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
